// File: design/lc_timing_pkg.sv
//////////////////////////////////////////////////////////////////////
// slot and microsecond timing widths for the link controller scan path
// defaults here feed the top-level parameters
//////////////////////////////////////////////////////////////////////

package lc_timing_pkg;

  //////////////////////////////////////////////////////////////////////
  // counter widths
  //////////////////////////////////////////////////////////////////////

  // 625 us slots, scan interval / window / response timeout
  typedef logic [15:0] slot_cnt_t;

  // microsecond strobes within one slot, 625 fits in 11 bits
  typedef logic [10:0] us_cnt_t;

  typedef logic [9:0] rand_t;  // inquiry back-off limit in us

  //////////////////////////////////////////////////////////////////////
  // default timing
  //////////////////////////////////////////////////////////////////////

  // one slot is 625 us
  parameter int unsigned DEF_SLOT_US = 625;

  // slots to wait for the master FHS in page response
  parameter int unsigned DEF_RESP_TO_SLOTS = 8;

endpackage

// File: design/lc_link_pkg.sv
//////////////////////////////////////////////////////////////////////
// link-level types: access code, correlator count, FHS count and the
// scan controller state encoding
//////////////////////////////////////////////////////////////////////

package lc_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // access code and counters
  //////////////////////////////////////////////////////////////////////

  typedef logic [63:0] sync_word_t;  // 64-bit sync word

  // agreeing bits, 0..64 needs 7 bits
  typedef logic [6:0] match_cnt_t;

  typedef logic [4:0] fhs_cnt_t;  // sent FHS responses, wraps at 32

  //////////////////////////////////////////////////////////////////////
  // scan controller states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    standby    = 5'd0,
    page_scan  = 5'd1,
    spr_txid   = 5'd2,   // slave response, ID out
    spr_rxfhs  = 5'd3,   // waiting on master FHS
    spr_ackfhs = 5'd4,   // ID out to ack the FHS
    inq_scan   = 5'd5,
    inq_txfhs  = 5'd6,
    inq_rand   = 5'd7,   // random back-off after FHS
    conn       = 5'd8
  } lc_state_e;

endpackage

// File: design/scan_window_gen.sv
//////////////////////////////////////////////////////////////////////
// periodic scan window, one instance per scan type
// counts slots within the interval, window high for the first
// window_len slots of each interval while enabled
//////////////////////////////////////////////////////////////////////

module scan_window_gen (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  logic                    tslot_p,
  input  logic                    scan_enable,
  input  lc_timing_pkg::slot_cnt_t interval,
  input  lc_timing_pkg::slot_cnt_t window_len,
  output logic                    scan_window
);

  import lc_timing_pkg::*;

  slot_cnt_t slot_cnt;
  slot_cnt_t slot_cnt_nxt;
  logic      last_slot;

  // interval of 0 treated like 1
  assign last_slot = (interval == '0) || (slot_cnt >= interval - 16'd1);

  always_comb
  begin
    if (!scan_enable)
      slot_cnt_nxt = '0;
    else if (tslot_p)
      slot_cnt_nxt = last_slot ? '0 : slot_cnt + 16'd1;
    else
      slot_cnt_nxt = slot_cnt;
  end

  // window registered from the next count so it moves with the count
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      slot_cnt    <= '0;
      scan_window <= 1'b0;
    end
    else
    begin
      slot_cnt    <= slot_cnt_nxt;
      scan_window <= scan_enable && (slot_cnt_nxt < window_len);
    end
  end

endmodule

// File: design/access_code_correlator.sv
//////////////////////////////////////////////////////////////////////
// sync word correlator: counts agreeing bits against the reference at
// each us strobe, flags a hit, then times one slot to the response
//////////////////////////////////////////////////////////////////////

module access_code_correlator #(
  parameter int unsigned SLOT_US = lc_timing_pkg::DEF_SLOT_US
) (
  input  logic                     clk_6M,
  input  logic                     rstz,
  input  logic                     p_1us,
  input  logic                     corr_window,
  input  lc_link_pkg::sync_word_t  sync_in,
  input  lc_link_pkg::sync_word_t  ref_sync,
  input  lc_link_pkg::match_cnt_t  threshold,
  output logic                     corre_hit,
  output logic                     corr_slot_endp
);

  import lc_timing_pkg::*;
  import lc_link_pkg::*;

  match_cnt_t agree;
  logic       sample;
  logic       hit_now;
  logic       dly_busy;
  logic       dly_last;
  us_cnt_t    dly_cnt;

  //////////////////////////////////////////////////////////////////////
  // bit agreement
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    agree = '0;
    for (int i = 0; i < $bits(sync_in); i++)
    begin
      if (sync_in[i] == ref_sync[i])
        agree = agree + 7'd1;
    end
  end

  // no new compare while a response delay runs
  assign sample  = p_1us && corr_window && !dly_busy;
  assign hit_now = sample && (agree >= threshold);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      corre_hit <= 1'b0;
    else
      corre_hit <= hit_now;
  end

  //////////////////////////////////////////////////////////////////////
  // one-slot delay after the hit
  //////////////////////////////////////////////////////////////////////

  assign dly_last = dly_busy && p_1us && (dly_cnt == us_cnt_t'(SLOT_US - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      dly_busy       <= 1'b0;
      dly_cnt        <= '0;
      corr_slot_endp <= 1'b0;
    end
    else
    begin
      corr_slot_endp <= dly_last;
      if (hit_now)
        dly_busy <= 1'b1;
      else if (dly_last)
        dly_busy <= 1'b0;

      if (!dly_busy || dly_last)
        dly_cnt <= '0;
      else if (p_1us)
        dly_cnt <= dly_cnt + 11'd1;  // strobes since the hit
    end
  end

endmodule

// File: design/scan_state_ctrl.sv
//////////////////////////////////////////////////////////////////////
// slave scan FSM: page scan / inquiry scan, their responses and the
// connection state; also owns the scan enables and correlator setup
//////////////////////////////////////////////////////////////////////

module scan_state_ctrl #(
  parameter int unsigned SLOT_US       = lc_timing_pkg::DEF_SLOT_US,
  parameter int unsigned RESP_TO_SLOTS = lc_timing_pkg::DEF_RESP_TO_SLOTS
) (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  logic                    p_1us,
  input  logic                    tslot_p,
  input  logic                    ps_window,
  input  logic                    is_window,
  input  logic                    corre_hit,
  input  logic                    corr_slot_endp,
  input  logic                    regi_ps_enable_oneshot,
  input  logic                    regi_ps_cancel_oneshot,
  input  logic                    regi_is_enable_oneshot,
  input  logic                    regi_is_cancel_oneshot,
  input  logic                    regi_inquiry_diac,
  input  lc_link_pkg::sync_word_t regi_syncword_dac,
  input  lc_link_pkg::sync_word_t regi_syncword_giac,
  input  lc_link_pkg::sync_word_t regi_syncword_diac,
  input  lc_timing_pkg::rand_t    regi_is_max_rand,
  input  logic                    regi_detach_oneshot,
  output logic                    ps_enable,
  output logic                    is_enable,
  output logic                    corr_window,
  output lc_link_pkg::sync_word_t ref_sync,
  output logic                    ps,
  output logic                    is,
  output logic                    spr,
  output logic                    ir,
  output logic                    conns,
  output logic                    tx_packet_st_p,
  output lc_link_pkg::fhs_cnt_t   counter_is_fhs
);

  import lc_timing_pkg::*;
  import lc_link_pkg::*;

  lc_state_e cs;
  lc_state_e ns;
  us_cnt_t   us_cnt;    // us strobes since state entry
  slot_cnt_t to_cnt;    // slots spent waiting for FHS
  logic      txfhs_done;
  logic      txid_done;
  logic      rand_done;
  logic      resp_to;
  logic      enter_conn;
  logic      scan_resp;

  assign txfhs_done = (cs == inq_txfhs) && p_1us && (us_cnt == us_cnt_t'(SLOT_US - 1));
  assign txid_done  = (cs == spr_txid) && p_1us && (us_cnt == us_cnt_t'(SLOT_US / 2 - 1));
  assign rand_done  = (cs == inq_rand) && p_1us && (us_cnt == {1'b0, regi_is_max_rand});
  assign resp_to    = (cs == spr_rxfhs) && tslot_p
                      && (to_cnt == slot_cnt_t'(RESP_TO_SLOTS - 1));
  assign enter_conn = (cs == spr_ackfhs) && tslot_p;
  assign scan_resp  = ((cs == page_scan) || (cs == inq_scan)) && corr_slot_endp;

  //////////////////////////////////////////////////////////////////////
  // scan enables
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      ps_enable <= 1'b0;
      is_enable <= 1'b0;
    end
    else
    begin
      if (regi_ps_enable_oneshot)
        ps_enable <= 1'b1;
      else if (regi_ps_cancel_oneshot || enter_conn)  // page scan stops once connected
        ps_enable <= 1'b0;

      if (regi_is_enable_oneshot)
        is_enable <= 1'b1;
      else if (regi_is_cancel_oneshot)
        is_enable <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ns = cs;
    case (cs)
      standby:
        if (is_window)
          ns = inq_scan;   // inquiry scan wins a tie
        else if (ps_window)
          ns = page_scan;
      page_scan:
        if (corr_slot_endp)
          ns = spr_txid;
        else if (!ps_window)
          ns = standby;
      spr_txid:
        if (txid_done)
          ns = spr_rxfhs;
      spr_rxfhs:
        if (corre_hit)
          ns = spr_ackfhs;
        else if (resp_to)
          ns = standby;
      spr_ackfhs:
        if (tslot_p)
          ns = conn;
      inq_scan:
        if (corr_slot_endp)
          ns = inq_txfhs;
        else if (!is_window)
          ns = standby;
      inq_txfhs:
        if (txfhs_done)
          ns = inq_rand;
      inq_rand:
        if (rand_done)
          ns = standby;
      conn:
        if (regi_detach_oneshot)
          ns = standby;
      default:
        ns = standby;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      cs             <= standby;
      us_cnt         <= '0;
      to_cnt         <= '0;
      tx_packet_st_p <= 1'b0;
      counter_is_fhs <= '0;
    end
    else
    begin
      cs             <= ns;
      tx_packet_st_p <= scan_resp || enter_conn;  // FHS / ID, then the ack ID

      // both counters restart on every state change
      if (ns != cs)
        us_cnt <= '0;
      else if (p_1us)
        us_cnt <= us_cnt + 11'd1;

      if (ns != cs)
        to_cnt <= '0;
      else if (tslot_p)
        to_cnt <= to_cnt + 16'd1;

      if (txfhs_done)
        counter_is_fhs <= counter_is_fhs + 5'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // correlator setup and status flags
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (cs)
      page_scan: corr_window = ps_window;
      inq_scan:  corr_window = is_window;
      spr_rxfhs: corr_window = 1'b1;
      default:   corr_window = 1'b0;
    endcase
  end

  // DAC outside inquiry scan
  assign ref_sync = (cs == inq_scan)
                    ? (regi_inquiry_diac ? regi_syncword_diac : regi_syncword_giac)
                    : regi_syncword_dac;

  assign ps    = (cs == page_scan);
  assign is    = (cs == inq_scan);
  assign spr   = (cs == spr_txid) || (cs == spr_rxfhs) || (cs == spr_ackfhs);
  assign ir    = (cs == inq_txfhs);
  assign conns = (cs == conn);

endmodule

// File: design/link_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// slave scan link controller top: two scan window generators, the
// sync word correlator and the scan FSM
//////////////////////////////////////////////////////////////////////

module link_ctrl_top #(
  parameter int unsigned SLOT_US       = lc_timing_pkg::DEF_SLOT_US,
  parameter int unsigned RESP_TO_SLOTS = lc_timing_pkg::DEF_RESP_TO_SLOTS
) (
  input  logic                     clk_6M,
  input  logic                     rstz,
  input  logic                     p_1us,
  input  logic                     tslot_p,
  input  lc_link_pkg::sync_word_t  sync_in,
  input  logic                     regi_ps_enable_oneshot,
  input  logic                     regi_ps_cancel_oneshot,
  input  lc_timing_pkg::slot_cnt_t regi_ps_interval,
  input  lc_timing_pkg::slot_cnt_t regi_ps_window,
  input  logic                     regi_is_enable_oneshot,
  input  logic                     regi_is_cancel_oneshot,
  input  lc_timing_pkg::slot_cnt_t regi_is_interval,
  input  lc_timing_pkg::slot_cnt_t regi_is_window,
  input  lc_link_pkg::match_cnt_t  regi_correthreshold,
  input  lc_link_pkg::sync_word_t  regi_syncword_dac,
  input  lc_link_pkg::sync_word_t  regi_syncword_giac,
  input  lc_link_pkg::sync_word_t  regi_syncword_diac,
  input  logic                     regi_inquiry_diac,
  input  lc_timing_pkg::rand_t     regi_is_max_rand,
  input  logic                     regi_detach_oneshot,
  output logic                     ps,
  output logic                     is,
  output logic                     spr,
  output logic                     ir,
  output logic                     conns,
  output logic                     tx_packet_st_p,
  output lc_link_pkg::fhs_cnt_t    counter_is_fhs
);

  import lc_link_pkg::*;

  logic       ps_enable;
  logic       is_enable;
  logic       ps_window;
  logic       is_window;
  logic       corr_window;
  sync_word_t ref_sync;
  logic       corre_hit;
  logic       corr_slot_endp;

  //////////////////////////////////////////////////////////////////////
  // scan windows
  //////////////////////////////////////////////////////////////////////

  scan_window_gen ps_window_u (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .tslot_p     (tslot_p),
    .scan_enable (ps_enable),
    .interval    (regi_ps_interval),
    .window_len  (regi_ps_window),
    .scan_window (ps_window)
  );

  scan_window_gen is_window_u (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .tslot_p     (tslot_p),
    .scan_enable (is_enable),
    .interval    (regi_is_interval),
    .window_len  (regi_is_window),
    .scan_window (is_window)
  );

  // single correlator shared by page and inquiry paths
  access_code_correlator #(
    .SLOT_US (SLOT_US)
  ) correlator_u (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .p_1us          (p_1us),
    .corr_window    (corr_window),
    .sync_in        (sync_in),
    .ref_sync       (ref_sync),
    .threshold      (regi_correthreshold),
    .corre_hit      (corre_hit),
    .corr_slot_endp (corr_slot_endp)
  );

  scan_state_ctrl #(
    .SLOT_US       (SLOT_US),
    .RESP_TO_SLOTS (RESP_TO_SLOTS)
  ) ctrl_u (
    .clk_6M                 (clk_6M),
    .rstz                   (rstz),
    .p_1us                  (p_1us),
    .tslot_p                (tslot_p),
    .ps_window              (ps_window),
    .is_window              (is_window),
    .corre_hit              (corre_hit),
    .corr_slot_endp         (corr_slot_endp),
    .regi_ps_enable_oneshot (regi_ps_enable_oneshot),
    .regi_ps_cancel_oneshot (regi_ps_cancel_oneshot),
    .regi_is_enable_oneshot (regi_is_enable_oneshot),
    .regi_is_cancel_oneshot (regi_is_cancel_oneshot),
    .regi_inquiry_diac      (regi_inquiry_diac),
    .regi_syncword_dac      (regi_syncword_dac),
    .regi_syncword_giac     (regi_syncword_giac),
    .regi_syncword_diac     (regi_syncword_diac),
    .regi_is_max_rand       (regi_is_max_rand),
    .regi_detach_oneshot    (regi_detach_oneshot),
    .ps_enable              (ps_enable),
    .is_enable              (is_enable),
    .corr_window            (corr_window),
    .ref_sync               (ref_sync),
    .ps                     (ps),
    .is                     (is),
    .spr                    (spr),
    .ir                     (ir),
    .conns                  (conns),
    .tx_packet_st_p         (tx_packet_st_p),
    .counter_is_fhs         (counter_is_fhs)
  );

endmodule

// File: verif/link_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the slave scan link controller: runs each line of the
// vector file as one test with a fresh reset, stops at the first error
//////////////////////////////////////////////////////////////////////

module link_ctrl_tb;

  import lc_timing_pkg::*;
  import lc_link_pkg::*;

  localparam int SLOT_US        = 16;
  localparam int RESP_TO_SLOTS  = 4;
  localparam int SLOTS_PER_TEST = 40;  // generous bound for the longest test

  localparam sync_word_t DAC_WORD  = 64'h4f2d_91c3_a5e8_0b76;
  localparam sync_word_t GIAC_WORD = 64'h9e8b_33c4_7a15_d06f;
  localparam sync_word_t DIAC_WORD = 64'h1b67_e0a9_5cd2_84f3;
  localparam rand_t      MAX_RAND  = 10'd10;

  logic       clk_6M;
  logic       rstz;
  logic       p_1us   = 1'b0;
  logic       tslot_p = 1'b0;
  sync_word_t sync_in;
  logic       regi_ps_enable_oneshot;
  logic       regi_ps_cancel_oneshot;
  slot_cnt_t  regi_ps_interval;
  slot_cnt_t  regi_ps_window;
  logic       regi_is_enable_oneshot;
  logic       regi_is_cancel_oneshot;
  slot_cnt_t  regi_is_interval;
  slot_cnt_t  regi_is_window;
  match_cnt_t regi_correthreshold;
  logic       regi_inquiry_diac;
  rand_t      regi_is_max_rand;
  logic       regi_detach_oneshot;
  logic       ps;
  logic       is;
  logic       spr;
  logic       ir;
  logic       conns;
  logic       tx_packet_st_p;
  fhs_cnt_t   counter_is_fhs;

  // strobe generator state
  int div_cnt = 0;
  int us_pos  = 0;

  // pulse and edge counters from the monitor
  int   tx_cnt       = 0;
  int   ir_rise_cnt  = 0;
  int   ir_fall_cnt  = 0;
  int   spr_fall_cnt = 0;
  logic ir_q         = 1'b0;
  logic spr_q        = 1'b0;

  string       lines[$];
  logic        vectors_loaded = 1'b0;
  logic [31:0] lfsr_state     = 32'h3f54;

  // current test, filled from one vector line
  string test_name;
  int    t_kind;       // 0 inquiry scan, 1 page scan
  int    t_int;
  int    t_win;
  int    t_thresh;
  int    t_diac;
  int    t_flips;
  int    t_second;
  int    t_exp_match;
  int    t_exp_tx;
  int    t_exp_fhs;
  int    t_exp_conns;

  link_ctrl_top #(
    .SLOT_US       (SLOT_US),
    .RESP_TO_SLOTS (RESP_TO_SLOTS)
  ) dut0 (
    .clk_6M                 (clk_6M),
    .rstz                   (rstz),
    .p_1us                  (p_1us),
    .tslot_p                (tslot_p),
    .sync_in                (sync_in),
    .regi_ps_enable_oneshot (regi_ps_enable_oneshot),
    .regi_ps_cancel_oneshot (regi_ps_cancel_oneshot),
    .regi_ps_interval       (regi_ps_interval),
    .regi_ps_window         (regi_ps_window),
    .regi_is_enable_oneshot (regi_is_enable_oneshot),
    .regi_is_cancel_oneshot (regi_is_cancel_oneshot),
    .regi_is_interval       (regi_is_interval),
    .regi_is_window         (regi_is_window),
    .regi_correthreshold    (regi_correthreshold),
    .regi_syncword_dac      (DAC_WORD),
    .regi_syncword_giac     (GIAC_WORD),
    .regi_syncword_diac     (DIAC_WORD),
    .regi_inquiry_diac      (regi_inquiry_diac),
    .regi_is_max_rand       (regi_is_max_rand),
    .regi_detach_oneshot    (regi_detach_oneshot),
    .ps                     (ps),
    .is                     (is),
    .spr                    (spr),
    .ir                     (ir),
    .conns                  (conns),
    .tx_packet_st_p         (tx_packet_st_p),
    .counter_is_fhs         (counter_is_fhs)
  );

  //////////////////////////////////////////////////////////////////////
  // clock, strobes, monitor, watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk_6M = 1'b0;
    forever #4 clk_6M = ~clk_6M;
  end

  // 1 us every 6 clocks, slot pulse on the last strobe of each slot
  always @(posedge clk_6M)
  begin
    p_1us   <= (div_cnt == 5);
    tslot_p <= (div_cnt == 5) && (us_pos == SLOT_US - 1);
    if (div_cnt == 5)
    begin
      div_cnt <= 0;
      us_pos  <= (us_pos == SLOT_US - 1) ? 0 : us_pos + 1;
    end
    else
      div_cnt <= div_cnt + 1;
  end

  always @(negedge clk_6M)
  begin
    ir_q  <= ir;
    spr_q <= spr;
    if (tx_packet_st_p)
      tx_cnt <= tx_cnt + 1;
    if (ir && !ir_q)
      ir_rise_cnt <= ir_rise_cnt + 1;
    if (!ir && ir_q)
      ir_fall_cnt <= ir_fall_cnt + 1;
    if (!spr && spr_q)
      spr_fall_cnt <= spr_fall_cnt + 1;
  end

  initial
  begin
    longint limit;
    wait (vectors_loaded);
    limit = longint'(lines.size()) * SLOTS_PER_TEST * SLOT_US * 6 * 8;
    #(limit);
    stop_with_fail("timeout: DUT never finished test");
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      stop_with_fail($sformatf("ERR %s %s: expected %0b actual %0b",
                               test_name, what, exp, act));
    end
  endtask

  task automatic check_fhs_count(input string what, input fhs_cnt_t exp, input fhs_cnt_t act);
    if (act !== exp)
    begin
      stop_with_fail($sformatf("ERR %s %s: expected %0d actual %0d",
                               test_name, what, exp, act));
    end
  endtask

  task automatic check_match(input string what, input match_cnt_t exp, input match_cnt_t act);
    if (act !== exp)
    begin
      stop_with_fail($sformatf("ERR %s %s: expected %0d actual %0d",
                               test_name, what, exp, act));
    end
  endtask

  task automatic check_pulse_count(input string what, input int exp, input int act);
    if (act != exp)
    begin
      stop_with_fail($sformatf("ERR %s %s: expected %0d actual %0d",
                               test_name, what, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  // reference word with exactly flips distinct bits inverted
  task automatic make_word(input sync_word_t ref_word, input int flips,
                           output sync_word_t word);
    sync_word_t  mask;
    int          val;
    logic [5:0]  pos;
    mask = '0;
    if (flips >= 64)
      mask = '1;
    else
      while ($countones(mask) < flips)
      begin
        take_bits(6, val);
        pos = 6'(val);
        mask[pos] = 1'b1;
      end
    word = ref_word ^ mask;
  endtask

  task automatic wait_us(input int n);
    repeat (n)
    begin
      do
        @(negedge clk_6M);
      while (!p_1us);
    end
  endtask

  task automatic wait_slot_edge();
    do
      @(negedge clk_6M);
    while (!tslot_p);
  endtask

  // one-shot right after a slot pulse so slot 0 of the scan starts clean
  task automatic start_scan(input logic inquiry);
    wait_slot_edge();
    @(posedge clk_6M);
    if (inquiry)
      regi_is_enable_oneshot <= 1'b1;
    else
      regi_ps_enable_oneshot <= 1'b1;
    @(posedge clk_6M);
    regi_is_enable_oneshot <= 1'b0;
    regi_ps_enable_oneshot <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk_6M);
    rstz                   <= 1'b0;
    regi_ps_enable_oneshot <= 1'b0;
    regi_ps_cancel_oneshot <= 1'b0;
    regi_is_enable_oneshot <= 1'b0;
    regi_is_cancel_oneshot <= 1'b0;
    regi_detach_oneshot    <= 1'b0;
    sync_in                <= '0;
    repeat (8) @(posedge clk_6M);
    rstz <= 1'b1;
    @(negedge clk_6M);
    check_flag("ps after reset", 1'b0, ps);
    check_flag("is after reset", 1'b0, is);
    check_flag("spr after reset", 1'b0, spr);
    check_flag("ir after reset", 1'b0, ir);
    check_flag("conns after reset", 1'b0, conns);
    check_flag("tx pulse after reset", 1'b0, tx_packet_st_p);
    check_fhs_count("fhs count after reset", 5'd0, counter_is_fhs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequences
  //////////////////////////////////////////////////////////////////////

  task automatic run_inquiry(input sync_word_t word, input sync_word_t ref_word);
    int tx0;
    int irr0;
    int irf0;
    tx0  = tx_cnt;
    irr0 = ir_rise_cnt;
    irf0 = ir_fall_cnt;
    @(posedge clk_6M);
    sync_in <= word;
    start_scan(1'b1);
    if (t_exp_tx == 0)
    begin
      // slot k of the scan lies in the window while k mod interval < window
      for (int k = 0; k < 2 * t_int; k++)
      begin
        wait_us(SLOT_US / 2);
        check_flag($sformatf("is in slot %0d", k), (k % t_int) < t_win, is);
        wait_slot_edge();
      end
    end
    else
    begin
      while (tx_cnt == tx0)
        @(negedge clk_6M);
      @(posedge clk_6M);
      sync_in <= ~ref_word;  // one response only
      while (ir_fall_cnt == irf0)
        @(negedge clk_6M);
      while (!is)
        @(negedge clk_6M);
      wait_slot_edge();
      wait_slot_edge();
    end
    check_pulse_count("tx pulses", t_exp_tx, tx_cnt - tx0);
    check_pulse_count("ir rises", t_exp_tx, ir_rise_cnt - irr0);
    check_pulse_count("ir falls", t_exp_tx, ir_fall_cnt - irf0);
    check_fhs_count("fhs count", fhs_cnt_t'(t_exp_fhs), counter_is_fhs);
    check_flag("conns", t_exp_conns != 0, conns);
  endtask

  task automatic run_page(input sync_word_t word, input sync_word_t ref_word);
    int tx0;
    int sprf0;
    tx0   = tx_cnt;
    sprf0 = spr_fall_cnt;
    @(posedge clk_6M);
    sync_in <= word;
    start_scan(1'b0);
    while (tx_cnt == tx0)
      @(negedge clk_6M);
    check_flag("spr after ID", 1'b1, spr);
    if (t_second == 0)
    begin
      @(posedge clk_6M);
      sync_in <= ~ref_word;  // master FHS never shows up
    end
    // spr falls on entry to conn or on the response timeout
    while (spr_fall_cnt == sprf0)
      @(negedge clk_6M);
    wait_slot_edge();
    wait_slot_edge();
    check_pulse_count("tx pulses", t_exp_tx, tx_cnt - tx0);
    check_flag("conns", t_exp_conns != 0, conns);
    check_fhs_count("fhs count", fhs_cnt_t'(t_exp_fhs), counter_is_fhs);
    if (t_exp_conns != 0)
    begin
      wait_us(SLOT_US / 2);
      check_flag("ps while connected", 1'b0, ps);
      @(posedge clk_6M);
      regi_detach_oneshot <= 1'b1;
      @(posedge clk_6M);
      regi_detach_oneshot <= 1'b0;
      wait_us(1);
      check_flag("conns after detach", 1'b0, conns);
      // a full interval, so a still running page scan would show up
      for (int k = 0; k < t_int; k++)
      begin
        wait_slot_edge();
        wait_us(SLOT_US / 2);
        check_flag($sformatf("ps after detach slot %0d", k), 1'b0, ps);
      end
      start_scan(1'b0);
      wait_us(SLOT_US / 2);
      check_flag("ps after new enable", 1'b1, ps);
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    r;
    string line;
    fd = $fopen("verif/link_ctrl_vectors.txt", "r");
    if (fd == 0)
      stop_with_fail("cannot open verif/link_ctrl_vectors.txt");
    while (!$feof(fd))
    begin
      line = "";
      r = $fgets(line, fd);
      if (r > 0 && line.len() > 2 && line.getc(0) != "#")
        lines.push_back(line);
    end
    $fclose(fd);
    if (lines.size() == 0)
      stop_with_fail("vector file holds no tests");
  endtask

  task automatic parse_vector(input string line);
    logic [8*32-1:0] name_vec;
    int              n;
    n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name_vec, t_kind, t_int,
                t_win, t_thresh, t_diac, t_flips, t_second, t_exp_match, t_exp_tx,
                t_exp_fhs, t_exp_conns);
    if (n != 12)
      stop_with_fail($sformatf("malformed vector line: %s", line));
    test_name = $sformatf("%0s", name_vec);
  endtask

  task automatic run_test();
    sync_word_t ref_word;
    sync_word_t word;
    apply_reset();
    @(posedge clk_6M);
    regi_correthreshold <= match_cnt_t'(t_thresh);
    regi_inquiry_diac   <= (t_diac != 0);
    regi_ps_interval    <= slot_cnt_t'(t_int);
    regi_ps_window      <= slot_cnt_t'(t_win);
    regi_is_interval    <= slot_cnt_t'(t_int);
    regi_is_window      <= slot_cnt_t'(t_win);
    if (t_kind == 1)
      ref_word = DAC_WORD;
    else
      ref_word = (t_diac != 0) ? DIAC_WORD : GIAC_WORD;
    make_word(ref_word, t_flips, word);
    check_match("agreeing bits", match_cnt_t'(t_exp_match),
                match_cnt_t'($countones(~(word ^ ref_word))));
    if (t_kind == 1)
      run_page(word, ref_word);
    else
      run_inquiry(word, ref_word);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rstz                   <= 1'b0;
    sync_in                <= '0;
    regi_ps_enable_oneshot <= 1'b0;
    regi_ps_cancel_oneshot <= 1'b0;
    regi_ps_interval       <= '0;
    regi_ps_window         <= '0;
    regi_is_enable_oneshot <= 1'b0;
    regi_is_cancel_oneshot <= 1'b0;
    regi_is_interval       <= '0;
    regi_is_window         <= '0;
    regi_correthreshold    <= '0;
    regi_inquiry_diac      <= 1'b0;
    regi_is_max_rand       <= MAX_RAND;
    regi_detach_oneshot    <= 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    foreach (lines[i])
    begin
      parse_vector(lines[i]);
      run_test();
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verif/link_ctrl_vectors.txt
# name kind(0 inquiry,1 page) interval window threshold diac flips second_match
#   exp_agreeing_bits exp_tx_pulses exp_fhs_count exp_conns
inq_window_shape 0 5 2 56 0 64 0 0 0 0 0
inq_giac_match 0 8 6 56 0 3 0 61 1 1 0
inq_diac_at_thresh 0 8 6 60 1 4 0 60 1 1 0
inq_below_thresh 0 6 3 56 0 9 0 55 0 0 0
inq_diac_below 0 4 3 60 1 5 0 59 0 0 0
page_connect 1 6 4 52 0 6 1 58 2 0 1
page_at_thresh 1 8 4 58 0 6 1 58 2 0 1
page_resp_timeout 1 6 4 52 0 2 0 62 1 0 0

// File: tb.f
design/lc_timing_pkg.sv
design/lc_link_pkg.sv
design/scan_window_gen.sv
design/access_code_correlator.sv
design/scan_state_ctrl.sv
design/link_ctrl_top.sv
verif/link_ctrl_tb.sv

// File: Makefile
TOP := link_ctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f tb.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
